// ==== Makefile ====
# Verilator build and run of the board I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_sonata_io
FILELIST  ?= sonata_io.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/sonata_io_tests.txt ====
# op field data expect: W addr wdata|RND pslverr, R addr rdata|RND pslverr, P bank pads -, X low_cycles - -
# I bus ctrl scl_sda: ctrl in binary is scl_oe sda_oe scl_taps[2:0] sda_taps[2:0], bus 0 uses taps 1:0
R 00 00000000 0
R 24 00000000 0
W 00 RND 0
R 00 RND 0
W 04 000007ff 0
R 04 000007ff 0
W 10 ffffffff 0
R 10 000003ff 0
W 14 RND 0
R 14 RND 0
W 20 RND 0
R 20 RND 0
W 24 0000a5a5 0
R 24 0000a5a5 0
P rp 2aa -
R 08 000002aa 0
P ard 155 -
R 18 00000155 0
P pmod c3e1 -
R 28 0000c3e1 0
P sw 1ffe -
R 38 00000001 0
P sw 00ff -
R 38 00001f00 0
R 30 00000000 0
R 34 00000000 0
W 0c 12345678 1
R 0c 00000000 1
W 40 ffffffff 1
R 80 00000000 1
W c4 00000000 1
W 08 ffffffff 1
W 2c ffffffff 1
W 30 ffffffff 1
W 34 ffffffff 1
R 04 000007ff 0
R 24 0000a5a5 0
R 20 RND 0
I 0 00111111 11
I 0 10101111 01
I 0 01111110 10
I 0 00011011 11
I 1 11011111 01
I 1 00111110 10
I 1 11000000 00
I 1 00111111 11
X 3 - -
R 00 00000000 0
R 04 00000000 0
R 14 00000000 0
R 24 00000000 0
R 38 00001f00 0

// ==== bench/tb_sonata_io.sv ====
/*
 * Testbench for the board I/O layer. Runs the operations listed in the tests
 * file against the APB port, the GPIO and switch pads and the I2C taps.
 */
`timescale 1ns/100ps

module tb_sonata_io;
  import sonata_io_pkg::*;

  localparam int    RstHold   = 16;
  localparam string TestsFile = "bench/sonata_io_tests.txt";

  logic                 clk;
  logic                 arst_n;
  logic                 pll_locked;
  logic                 rst_btn_n;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [ADDR_W-1:0]    paddr;
  logic [DATA_W-1:0]    pwdata;
  logic [DATA_W-1:0]    prdata;
  logic                 pready;
  logic                 pslverr;
  logic [RP_GP_W-1:0]   rp_in, rp_out, rp_oe;
  logic [ARD_GP_W-1:0]  ard_in, ard_out, ard_oe;
  logic [PMOD_GP_W-1:0] pmod_in, pmod_out, pmod_oe;
  logic [4:0]           nav_sw;
  logic [7:0]           usr_sw;
  logic                 i2c0_scl_oe, i2c0_sda_oe, i2c0_scl, i2c0_sda;
  logic [1:0]           i2c0_scl_pad, i2c0_sda_pad, i2c0_scl_pad_oe, i2c0_sda_pad_oe;
  logic                 i2c1_scl_oe, i2c1_sda_oe, i2c1_scl, i2c1_sda;
  logic [2:0]           i2c1_scl_pad, i2c1_sda_pad, i2c1_scl_pad_oe, i2c1_sda_pad_oe;
  logic                 rst_sys_n;
  logic                 led_bootok;

  logic [PMOD_GP_W-1:0] out_model [3];  // Expected OUT per GPIO bank
  logic [PMOD_GP_W-1:0] oe_model [3];
  logic [DATA_W-1:0]    last_rnd;
  logic [15:0]          lfsr_q;
  int                   max_cycles;
  int                   cycle_cnt;

  sonata_io #(.RstHoldCycles(RstHold)) DUT (
    .clk_sys_i(clk), .arst_n_i(arst_n), .pll_locked_i(pll_locked), .rst_btn_ni(rst_btn_n),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .rp_gp_i(rp_in), .rp_gp_o(rp_out), .rp_gp_oe_o(rp_oe),
    .ard_gp_i(ard_in), .ard_gp_o(ard_out), .ard_gp_oe_o(ard_oe),
    .pmod_gp_i(pmod_in), .pmod_gp_o(pmod_out), .pmod_gp_oe_o(pmod_oe),
    .nav_sw_i(nav_sw), .usr_sw_i(usr_sw),
    .i2c0_scl_oe_i(i2c0_scl_oe), .i2c0_sda_oe_i(i2c0_sda_oe),
    .i2c0_scl_o(i2c0_scl), .i2c0_sda_o(i2c0_sda),
    .i2c0_scl_pad_i(i2c0_scl_pad), .i2c0_sda_pad_i(i2c0_sda_pad),
    .i2c0_scl_pad_oe_o(i2c0_scl_pad_oe), .i2c0_sda_pad_oe_o(i2c0_sda_pad_oe),
    .i2c1_scl_oe_i(i2c1_scl_oe), .i2c1_sda_oe_i(i2c1_sda_oe),
    .i2c1_scl_o(i2c1_scl), .i2c1_sda_o(i2c1_sda),
    .i2c1_scl_pad_i(i2c1_scl_pad), .i2c1_sda_pad_i(i2c1_sda_pad),
    .i2c1_scl_pad_oe_o(i2c1_scl_pad_oe), .i2c1_sda_pad_oe_o(i2c1_sda_pad_oe),
    .rst_sys_no(rst_sys_n), .led_bootok_o(led_bootok)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit follows the length of the tests file
  initial begin
    cycle_cnt = 0;
    while (max_cycles == 0 || cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on timeout");
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_pins(input string name, input logic [PMOD_GP_W-1:0] got,
                            input logic [PMOD_GP_W-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [DATA_W-1:0] rnd_word();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < DATA_W; i++) w = {w[DATA_W-2:0], lfsr_step()};
    return w;
  endfunction

  function automatic logic [DATA_W-1:0] width_mask(input logic [ADDR_W-1:0] addr);
    int w;
    case (io_bank_e'(addr[BANK_MSB:BANK_LSB]))
      BANK_RP:   w = RP_GP_W;
      BANK_ARD:  w = ARD_GP_W;
      BANK_PMOD: w = PMOD_GP_W;
      default:   w = SW_W;
    endcase
    return {DATA_W{1'b1}} >> (DATA_W - w);
  endfunction

  task automatic clear_model();
    for (int i = 0; i < 3; i++) begin
      out_model[i] = '0;
      oe_model[i]  = '0;
    end
  endtask

  // Only OUT and OE of a mapped GPIO bank take writes
  task automatic update_model(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [1:0] bank;
    bank = addr[BANK_MSB:BANK_LSB];
    if (addr[7:6] == 2'b00 && bank != BANK_SW) begin
      if (addr[REG_MSB:REG_LSB] == REG_OUT) out_model[bank] = PMOD_GP_W'(data & width_mask(addr));
      if (addr[REG_MSB:REG_LSB] == REG_OE) oe_model[bank] = PMOD_GP_W'(data & width_mask(addr));
    end
  endtask

  task automatic check_gpio_outputs();
    check_pins("rp_gp_o", PMOD_GP_W'(rp_out), out_model[0]);
    check_pins("rp_gp_oe_o", PMOD_GP_W'(rp_oe), oe_model[0]);
    check_pins("ard_gp_o", PMOD_GP_W'(ard_out), out_model[1]);
    check_pins("ard_gp_oe_o", PMOD_GP_W'(ard_oe), oe_model[1]);
    check_pins("pmod_gp_o", pmod_out, out_model[2]);
    check_pins("pmod_gp_oe_o", pmod_oe, oe_model[2]);
  endtask

  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  // Setup then access phase with the response sampled at the falling edge
  task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
    int waited;
    next_drive();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    next_drive();
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (pready !== 1'b1) begin
      waited++;
      if (waited > 8) fail_now("APB transfer never completed, pready stayed low");
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    next_drive();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic do_write(input string f_addr, input string f_data, input string f_err);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] rdata;
    logic              err;
    void'($sscanf(f_addr, "%h", addr));
    if (f_data == "RND") begin
      data     = rnd_word();
      last_rnd = data;
    end else begin
      void'($sscanf(f_data, "%h", data));
    end
    apb_transfer(1'b1, addr, data, rdata, err);
    check_err($sformatf("pslverr_o on write to 0x%h", addr), err, f_err == "1");
    update_model(addr, data);
    @(negedge clk);
    check_gpio_outputs();
  endtask

  task automatic do_read(input string f_addr, input string f_data, input string f_err);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] rdata;
    logic              err;
    void'($sscanf(f_addr, "%h", addr));
    if (f_data == "RND") exp = last_rnd & width_mask(addr);
    else void'($sscanf(f_data, "%h", exp));
    apb_transfer(1'b0, addr, '0, rdata, err);
    check_data($sformatf("prdata_o at 0x%h", addr), rdata, exp);
    check_err($sformatf("pslverr_o on read of 0x%h", addr), err, f_err == "1");
  endtask

  task automatic set_pads(input string bank, input string f_val);
    logic [DATA_W-1:0] v;
    void'($sscanf(f_val, "%h", v));
    next_drive();
    if (bank == "rp") rp_in = v[RP_GP_W-1:0];
    else if (bank == "ard") ard_in = v[ARD_GP_W-1:0];
    else if (bank == "pmod") pmod_in = v[PMOD_GP_W-1:0];
    else if (bank == "sw") begin
      usr_sw = v[12:5];  // User switches sit above the joystick
      nav_sw = v[4:0];
    end else fail_now({"Unknown pad bank in tests file: ", bank});
    repeat (3) @(posedge clk);
  endtask

  task automatic set_i2c(input string bus, input string f_ctrl, input string f_lvl);
    logic [7:0] c;
    logic [1:0] lvl;
    void'($sscanf(f_ctrl, "%b", c));
    void'($sscanf(f_lvl, "%b", lvl));
    next_drive();
    if (bus == "0") begin
      i2c0_scl_oe  = c[7];
      i2c0_sda_oe  = c[6];
      i2c0_scl_pad = c[4:3];
      i2c0_sda_pad = c[1:0];
    end else begin
      i2c1_scl_oe  = c[7];
      i2c1_sda_oe  = c[6];
      i2c1_scl_pad = c[5:3];
      i2c1_sda_pad = c[2:0];
    end
    @(negedge clk);
    if (bus == "0") begin
      check_pins("i2c0_scl_pad_oe_o", PMOD_GP_W'(i2c0_scl_pad_oe), PMOD_GP_W'({2{c[7]}}));
      check_pins("i2c0_sda_pad_oe_o", PMOD_GP_W'(i2c0_sda_pad_oe), PMOD_GP_W'({2{c[6]}}));
    end else begin
      check_pins("i2c1_scl_pad_oe_o", PMOD_GP_W'(i2c1_scl_pad_oe), PMOD_GP_W'({3{c[7]}}));
      check_pins("i2c1_sda_pad_oe_o", PMOD_GP_W'(i2c1_sda_pad_oe), PMOD_GP_W'({3{c[6]}}));
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_level(bus == "0" ? "i2c0_scl_o" : "i2c1_scl_o", bus == "0" ? i2c0_scl : i2c1_scl, lvl[1]);
    check_level(bus == "0" ? "i2c0_sda_o" : "i2c1_sda_o", bus == "0" ? i2c0_sda : i2c1_sda, lvl[0]);
  endtask

  // Counts edges from the release until rst_sys_no rises
  task automatic time_reset_release();
    int n;
    n = 0;
    while (rst_sys_n !== 1'b1 && n < RstHold + 2) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (rst_sys_n !== 1'b1) check_level("led_bootok_o", led_bootok, 1'b0);
    end
    if (rst_sys_n !== 1'b1) begin
      fail_now($sformatf("System reset still active %0d cycles after release", n));
    end
    if (n < RstHold) fail_now($sformatf("System reset released after %0d cycles, too early", n));
    check_level("led_bootok_o", led_bootok, 1'b1);
    check_gpio_outputs();
  endtask

  task automatic press_button(input string f_cycles);
    int n;
    void'($sscanf(f_cycles, "%d", n));
    next_drive();
    rst_btn_n = 1'b0;
    repeat (n) @(posedge clk);
    @(negedge clk);
    check_level("rst_sys_no", rst_sys_n, 1'b0);
    check_level("led_bootok_o", led_bootok, 1'b0);
    clear_model();
    check_gpio_outputs();
    next_drive();
    rst_btn_n = 1'b1;
    time_reset_release();
  endtask

  initial begin
    int    fd;
    int    n_lines;
    string line;
    string op;
    string f1;
    string f2;
    string f3;
    arst_n       = 1'b0;
    pll_locked   = 1'b0;
    rst_btn_n    = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    rp_in        = '0;
    ard_in       = '0;
    pmod_in      = '0;
    nav_sw       = '1;  // All switches off
    usr_sw       = '1;
    i2c0_scl_oe  = 1'b0;
    i2c0_sda_oe  = 1'b0;
    i2c0_scl_pad = '1;  // Pulled-up idle bus
    i2c0_sda_pad = '1;
    i2c1_scl_oe  = 1'b0;
    i2c1_sda_oe  = 1'b0;
    i2c1_scl_pad = '1;
    i2c1_sda_pad = '1;
    lfsr_q       = 16'd38;
    last_rnd     = '0;
    clear_model();

    n_lines = 0;
    fd = $fopen(TestsFile, "r");
    if (fd == 0) fail_now({"Cannot open the tests file ", TestsFile});
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") n_lines++;
    end
    $fclose(fd);
    max_cycles = 40 * n_lines + 100;

    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;

    // PLL still unlocked so the system stays in reset
    repeat (RstHold + 4) begin
      @(negedge clk);
      check_level("rst_sys_no", rst_sys_n, 1'b0);
      check_level("led_bootok_o", led_bootok, 1'b0);
    end
    next_drive();
    pll_locked = 1'b1;
    time_reset_release();

    fd = $fopen(TestsFile, "r");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op.getc(0) == "#") begin
        void'($fgets(line, fd));
      end else begin
        if ($fscanf(fd, "%s %s %s", f1, f2, f3) != 3) fail_now({"Incomplete test line: ", op});
        if (op == "W") do_write(f1, f2, f3);
        else if (op == "R") do_read(f1, f2, f3);
        else if (op == "P") set_pads(f1, f2);
        else if (op == "I") set_i2c(f1, f2, f3);
        else if (op == "X") press_button(f1);
        else fail_now({"Unknown opcode in tests file: ", op});
      end
    end
    $fclose(fd);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== design/apb_bank_decode.sv ====
/*
 * Routes the top-level APB port to one of the four register banks by
 * address bits 5:4 and answers accesses outside the map with an error.
 */
`timescale 1ns/100ps

module apb_bank_decode (
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [sonata_io_pkg::ADDR_W-1:0] paddr_i,
  input  logic [sonata_io_pkg::DATA_W-1:0] pwdata_i,
  output logic [sonata_io_pkg::DATA_W-1:0] prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  apb_if.requester                         banks [4]
);
  import sonata_io_pkg::*;

  io_bank_e          bank_sel;
  logic              mapped;
  logic [DATA_W-1:0] bank_rdata [4];
  logic [3:0]        bank_ready;
  logic [3:0]        bank_err;

  assign bank_sel = io_bank_e'(paddr_i[BANK_MSB:BANK_LSB]);
  assign mapped   = (paddr_i[ADDR_W-1:ZERO_LSB] == '0);

  for (genvar i = 0; i < 4; i++) begin : g_bank
    // Only the addressed bank sees psel
    assign banks[i].psel    = psel_i && mapped && (bank_sel == io_bank_e'(i));
    assign banks[i].penable = penable_i;
    assign banks[i].pwrite  = pwrite_i;
    assign banks[i].paddr   = paddr_i;
    assign banks[i].pwdata  = pwdata_i;

    assign bank_rdata[i] = banks[i].prdata;
    assign bank_ready[i] = banks[i].pready;
    assign bank_err[i]   = banks[i].pslverr;
  end

  // Unmapped accesses complete here with an error
  always_comb begin
    if (mapped) begin
      prdata_o  = bank_rdata[bank_sel];
      pready_o  = bank_ready[bank_sel];
      pslverr_o = bank_err[bank_sel];
    end else begin
      prdata_o  = '0;
      pready_o  = 1'b1;
      pslverr_o = psel_i;
    end
  end

endmodule

// ==== design/apb_if.sv ====
/*
 * APB bundle between the bank decoder and the register banks.
 * The decoder takes the requester side, each bank the completer side.
 */
`timescale 1ns/100ps

interface apb_if;
  import sonata_io_pkg::*;

  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

// ==== design/gpio_bank.sv ====
/*
 * APB register bank for one group of pins. Holds output and output-enable
 * registers and a synchronized input register. With ReadOnly set it serves
 * as a plain input bank, with InvertIn for active-low switches.
 */
`timescale 1ns/100ps

module gpio_bank #(
  parameter int unsigned Width    = 8,
  parameter bit          ReadOnly = 1'b0,
  parameter bit          InvertIn = 1'b0
) (
  input  logic             clk_sys_i,
  input  logic             rst_sys_ni,
  apb_if.completer         apb,
  input  logic [Width-1:0] gp_i,
  output logic [Width-1:0] gp_o,
  output logic [Width-1:0] gp_oe_o
);
  import sonata_io_pkg::*;

  logic [Width-1:0]                  out_q;
  logic [Width-1:0]                  oe_q;
  logic [SYNC_STAGES-1:0][Width-1:0] sync_q;
  logic [Width-1:0]                  pad_in;
  logic [Width-1:0]                  in_val;
  io_reg_e                           reg_sel;
  logic                              wr_en;
  logic [DATA_W-1:0]                 rdata;
  logic                              err;

  assign reg_sel = io_reg_e'(apb.paddr[REG_MSB:REG_LSB]);

  // Writes land in the access phase; read-only banks never write
  assign wr_en = apb.psel && apb.penable && apb.pwrite && !ReadOnly;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        REG_OUT: out_q <= apb.pwdata[Width-1:0];
        REG_OE:  oe_q  <= apb.pwdata[Width-1:0];
        default: ;  // IN and register 3 take no writes
      endcase
    end
  end

  // Inversion sits ahead of the synchronizer so reset reads back as zero
  assign pad_in = gp_i ^ {Width{InvertIn}};

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], pad_in};
    end
  end

  assign in_val = sync_q[SYNC_STAGES-1];

  // Read mux and error decode
  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (reg_sel)
      REG_OUT: begin
        if (!ReadOnly) rdata = DATA_W'(out_q);
        err = ReadOnly && apb.pwrite;
      end
      REG_OE: begin
        if (!ReadOnly) rdata = DATA_W'(oe_q);
        err = ReadOnly && apb.pwrite;
      end
      REG_IN: begin
        rdata = DATA_W'(in_val);
        err   = apb.pwrite;  // Input register is read-only everywhere
      end
      default: err = 1'b1;   // Unmapped register
    endcase
  end

  assign apb.prdata  = rdata;
  assign apb.pslverr = apb.psel && err;
  assign apb.pready  = 1'b1;  // No wait states

  assign gp_o    = out_q;
  assign gp_oe_o = oe_q;

  // Every setup phase from the decoder is followed by a completed access phase
  a_access_completes: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    apb.psel && !apb.penable |=> apb.psel && apb.penable && apb.pready
  ) else $error("APB setup phase not followed by a one-cycle access");

endmodule

// ==== design/i2c_bus_split.sv ====
/*
 * Fans one I2C controller out to several open-drain header taps.
 * Tap inputs are wired-AND together and synchronized back to the controller.
 */
`timescale 1ns/100ps

module i2c_bus_split #(
  parameter int unsigned Taps = 2
) (
  input  logic            clk_sys_i,
  input  logic            rst_sys_ni,
  input  logic            scl_oe_i,
  input  logic            sda_oe_i,
  input  logic [Taps-1:0] scl_pad_i,
  input  logic [Taps-1:0] sda_pad_i,
  output logic [Taps-1:0] scl_pad_oe_o,
  output logic [Taps-1:0] sda_pad_oe_o,
  output logic            scl_o,
  output logic            sda_o
);
  import sonata_io_pkg::*;

  logic [SYNC_STAGES-1:0][1:0] sync_q;  // {scl, sda} per stage

  // Enabled tap pulls its pad low
  assign scl_pad_oe_o = {Taps{scl_oe_i}};
  assign sda_pad_oe_o = {Taps{sda_oe_i}};

  // Idle bus is high
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], {&scl_pad_i, &sda_pad_i}};
    end
  end

  assign scl_o = sync_q[SYNC_STAGES-1][1];
  assign sda_o = sync_q[SYNC_STAGES-1][0];

endmodule

// ==== design/rst_ctrl.sv ====
/*
 * System reset controller. Holds the system in reset until the PLL has locked
 * and the reset button is released, then waits a fixed number of cycles.
 */
`timescale 1ns/100ps

module rst_ctrl #(
  parameter int unsigned RstHoldCycles = 16
) (
  input  logic clk_sys_i,
  input  logic arst_n_i,
  input  logic pll_locked_i,
  input  logic rst_btn_ni,
  output logic rst_sys_no
);

  // Counter just wide enough for the hold time
  localparam int unsigned CntW = $clog2(RstHoldCycles + 1);

  logic            release_ok;
  logic [CntW-1:0] hold_cnt_q;
  logic            rst_q;

  assign release_ok = pll_locked_i & rst_btn_ni;

  // Any drop of lock or a button press restarts the hold time
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_cnt_q <= '0;
      rst_q      <= 1'b0;
    end else if (!release_ok) begin
      hold_cnt_q <= '0;
      rst_q      <= 1'b0;
    end else if (!rst_q) begin
      if (hold_cnt_q == CntW'(RstHoldCycles - 1)) begin
        rst_q <= 1'b1;  // Last hold cycle
      end else begin
        hold_cnt_q <= hold_cnt_q + CntW'(1);
      end
    end
  end

  assign rst_sys_no = rst_q;

  // Release is only ever decided on a cycle that saw the PLL locked
  a_no_release_unlocked: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    $rose(rst_sys_no) |-> $past(pll_locked_i)
  ) else $error("System reset released while PLL unlocked");

  // Release needs lock and button good a full hold time earlier
  a_hold_time: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    $rose(rst_sys_no) |-> $past(release_ok, RstHoldCycles)
  ) else $error("System reset released before hold time");

endmodule

// ==== design/sonata_io.sv ====
/*
 * Board I/O layer: system reset, APB-mapped GPIO and switch banks, and the
 * I2C bus splitters for the headers. Pads appear as separate in, out and
 * enable ports so the board wrapper builds the tri-states.
 */
`timescale 1ns/100ps

module sonata_io #(
  parameter int unsigned RstHoldCycles = 16
) (
  input  logic                                clk_sys_i,
  input  logic                                arst_n_i,
  input  logic                                pll_locked_i,
  input  logic                                rst_btn_ni,

  // APB register port
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [sonata_io_pkg::ADDR_W-1:0]    paddr_i,
  input  logic [sonata_io_pkg::DATA_W-1:0]    pwdata_i,
  output logic [sonata_io_pkg::DATA_W-1:0]    prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,

  // GPIO pads
  input  logic [sonata_io_pkg::RP_GP_W-1:0]   rp_gp_i,
  output logic [sonata_io_pkg::RP_GP_W-1:0]   rp_gp_o,
  output logic [sonata_io_pkg::RP_GP_W-1:0]   rp_gp_oe_o,
  input  logic [sonata_io_pkg::ARD_GP_W-1:0]  ard_gp_i,
  output logic [sonata_io_pkg::ARD_GP_W-1:0]  ard_gp_o,
  output logic [sonata_io_pkg::ARD_GP_W-1:0]  ard_gp_oe_o,
  input  logic [sonata_io_pkg::PMOD_GP_W-1:0] pmod_gp_i,
  output logic [sonata_io_pkg::PMOD_GP_W-1:0] pmod_gp_o,
  output logic [sonata_io_pkg::PMOD_GP_W-1:0] pmod_gp_oe_o,

  // Active-low switches
  input  logic [4:0]                          nav_sw_i,
  input  logic [7:0]                          usr_sw_i,

  // I2C bus 0: QWIIC0 and HAT ID EEPROM
  input  logic                                i2c0_scl_oe_i,
  input  logic                                i2c0_sda_oe_i,
  output logic                                i2c0_scl_o,
  output logic                                i2c0_sda_o,
  input  logic [1:0]                          i2c0_scl_pad_i,
  input  logic [1:0]                          i2c0_sda_pad_i,
  output logic [1:0]                          i2c0_scl_pad_oe_o,
  output logic [1:0]                          i2c0_sda_pad_oe_o,

  // I2C bus 1: QWIIC1, R-Pi GPIO2/3 and mikroBUS
  input  logic                                i2c1_scl_oe_i,
  input  logic                                i2c1_sda_oe_i,
  output logic                                i2c1_scl_o,
  output logic                                i2c1_sda_o,
  input  logic [2:0]                          i2c1_scl_pad_i,
  input  logic [2:0]                          i2c1_sda_pad_i,
  output logic [2:0]                          i2c1_scl_pad_oe_o,
  output logic [2:0]                          i2c1_sda_pad_oe_o,

  output logic                                rst_sys_no,
  output logic                                led_bootok_o
);
  import sonata_io_pkg::*;

  logic rst_sys_n;

  apb_if bank_apb [4] ();

  rst_ctrl #(
    .RstHoldCycles(RstHoldCycles)
  ) u_rst_ctrl (
    .clk_sys_i   (clk_sys_i),
    .arst_n_i    (arst_n_i),
    .pll_locked_i(pll_locked_i),
    .rst_btn_ni  (rst_btn_ni),
    .rst_sys_no  (rst_sys_n)
  );

  assign rst_sys_no   = rst_sys_n;
  assign led_bootok_o = rst_sys_n;  // Lit once out of reset

  apb_bank_decode u_decode (
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .paddr_i  (paddr_i),
    .pwdata_i (pwdata_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .banks    (bank_apb)
  );

  gpio_bank #(.Width(RP_GP_W)) u_rp_bank (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_n),
    .apb       (bank_apb[BANK_RP]),
    .gp_i      (rp_gp_i),
    .gp_o      (rp_gp_o),
    .gp_oe_o   (rp_gp_oe_o)
  );

  gpio_bank #(.Width(ARD_GP_W)) u_ard_bank (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_n),
    .apb       (bank_apb[BANK_ARD]),
    .gp_i      (ard_gp_i),
    .gp_o      (ard_gp_o),
    .gp_oe_o   (ard_gp_oe_o)
  );

  gpio_bank #(.Width(PMOD_GP_W)) u_pmod_bank (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_n),
    .apb       (bank_apb[BANK_PMOD]),
    .gp_i      (pmod_gp_i),   // pmod1 above pmod0
    .gp_o      (pmod_gp_o),
    .gp_oe_o   (pmod_gp_oe_o)
  );

  // Switches pull to ground when on, software sees 1 for on
  gpio_bank #(
    .Width   (SW_W),
    .ReadOnly(1'b1),
    .InvertIn(1'b1)
  ) u_sw_bank (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_n),
    .apb       (bank_apb[BANK_SW]),
    .gp_i      ({usr_sw_i, nav_sw_i}),
    .gp_o      (),
    .gp_oe_o   ()
  );

  i2c_bus_split #(.Taps(2)) u_i2c0_split (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_n),
    .scl_oe_i    (i2c0_scl_oe_i),
    .sda_oe_i    (i2c0_sda_oe_i),
    .scl_pad_i   (i2c0_scl_pad_i),
    .sda_pad_i   (i2c0_sda_pad_i),
    .scl_pad_oe_o(i2c0_scl_pad_oe_o),
    .sda_pad_oe_o(i2c0_sda_pad_oe_o),
    .scl_o       (i2c0_scl_o),
    .sda_o       (i2c0_sda_o)
  );

  i2c_bus_split #(.Taps(3)) u_i2c1_split (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_n),
    .scl_oe_i    (i2c1_scl_oe_i),
    .sda_oe_i    (i2c1_sda_oe_i),
    .scl_pad_i   (i2c1_scl_pad_i),
    .sda_pad_i   (i2c1_sda_pad_i),
    .scl_pad_oe_o(i2c1_scl_pad_oe_o),
    .sda_pad_oe_o(i2c1_sda_pad_oe_o),
    .scl_o       (i2c1_scl_o),
    .sda_o       (i2c1_sda_o)
  );

endmodule

// ==== design/sonata_io_pkg.sv ====
/*
 * Shared widths, APB address map and register enums for the board I/O layer.
 * Imported by the decoder, the register banks and the top level.
 */
package sonata_io_pkg;

  // APB bus widths
  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 32;

  // Address map
  // [7:6] must be zero, [5:4] selects the bank, [3:2] selects the register
  localparam int unsigned ZERO_LSB = 6;
  localparam int unsigned BANK_MSB = 5;
  localparam int unsigned BANK_LSB = 4;
  localparam int unsigned REG_MSB  = 3;
  localparam int unsigned REG_LSB  = 2;

  typedef enum logic [1:0] {
    BANK_RP   = 2'd0,  // Raspberry Pi header
    BANK_ARD  = 2'd1,  // Arduino shield
    BANK_PMOD = 2'd2,  // Both PMOD connectors
    BANK_SW   = 2'd3   // Joystick and user switches
  } io_bank_e;

  // Register 3 is left unmapped in every bank
  typedef enum logic [1:0] {
    REG_OUT = 2'd0,
    REG_OE  = 2'd1,
    REG_IN  = 2'd2
  } io_reg_e;

  // Pin counts per bank
  localparam int unsigned RP_GP_W   = 11;
  localparam int unsigned ARD_GP_W  = 10;
  localparam int unsigned PMOD_GP_W = 16;
  localparam int unsigned SW_W      = 13;  // 8 user switches above 5 joystick

  // Depth of every input synchronizer
  localparam int unsigned SYNC_STAGES = 2;

endpackage

// ==== sonata_io.f ====
design/sonata_io_pkg.sv
design/apb_if.sv
design/rst_ctrl.sv
design/gpio_bank.sv
design/i2c_bus_split.sv
design/apb_bank_decode.sv
design/sonata_io.sv
bench/tb_sonata_io.sv
